// ==== run_sim.sh ====
#!/bin/sh
# build the uart testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_uart_top -f uart_periph.f \
    -o tb_uart_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_uart_top > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && exit 1
exit 0

// ==== tb_uart_top.sv ====
// **************************************************
// uart peripheral testbench: bus and line models,
// reference read model, compare tasks and tests
// **************************************************

`include "uart_macros.svh"

module tb_uart_top import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // wait limits, in cycles or status polls
    localparam int BUS_TIMEOUT  = 50;
    localparam int LINE_TIMEOUT = 2000;
    localparam int POLL_LIMIT   = 200;

    logic       clk;
    logic       rst_n;
    data_word_t addr_i;
    data_word_t data_i;
    byte_sel_t  sel_i;
    logic       we_i;
    logic       req_valid_i;
    logic       rsp_ready_i;
    logic       rx_i;
    data_word_t data_o;
    logic       req_ready_o;
    logic       rsp_valid_o;
    logic       tx_o;

    // shadow of the register state
    byte_t      exp_ctrl;
    baud_div_t  exp_baud;
    logic       exp_busy;
    logic       exp_rx_over;
    byte_t      exp_rx_data;

    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          test_mark;

    uart_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .sel_i       (sel_i),
        .we_i        (we_i),
        .req_valid_i (req_valid_i),
        .rsp_ready_i (rsp_ready_i),
        .rx_i        (rx_i),
        .data_o      (data_o),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .tx_o        (tx_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected read value from the shadow state
    function automatic data_word_t expected_read(input reg_off_t off);
        data_word_t value;
        value = '0;
        case (off)
            `UART_OFF_CTRL:   value[7:0] = exp_ctrl;
            `UART_OFF_STATUS: begin
                value[`UART_STAT_TX_BUSY] = exp_busy;
                value[`UART_STAT_RX_OVER] = exp_rx_over;
            end
            // upper half reads zero
            `UART_OFF_BAUD:   value[15:0] = exp_baud;
            `UART_OFF_RXDATA: value[7:0] = exp_rx_data;
            default:          value = '0;
        endcase
        return value;
    endfunction

    // apply one write to the shadow, lane rules per register
    function automatic void shadow_write(input reg_off_t off, input data_word_t data,
                                         input byte_sel_t sel);
        if (off == `UART_OFF_CTRL && sel[0]) begin
            exp_ctrl = data[7:0];
        end
        if (off == `UART_OFF_BAUD && sel[0]) begin
            exp_baud[7:0] = data[7:0];
        end
        if (off == `UART_OFF_BAUD && sel[1]) begin
            exp_baud[15:8] = data[15:8];
        end
        // busy is read-only, only rx done is writable
        if (off == `UART_OFF_STATUS && sel[0]) begin
            exp_rx_over = data[`UART_STAT_RX_OVER];
        end
        // frame starts only when enabled and idle
        if (off == `UART_OFF_TXDATA && sel[0] && exp_ctrl[`UART_CTRL_TX_EN] && !exp_busy) begin
            exp_busy = 1'b1;
        end
    endfunction

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic report_test(input string name);
        if (errors == test_mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    // one request, returns the response word
    task automatic bus_access(input logic write, input data_word_t addr,
                              input data_word_t wdata, input byte_sel_t sel,
                              output data_word_t rdata);
        int wait_cnt;
        rdata = '0;
        @(posedge clk);
        addr_i      <= addr;
        data_i      <= wdata;
        sel_i       <= sel;
        we_i        <= write;
        req_valid_i <= 1'b1;
        // hold the request until req_ready_o
        wait_cnt = 0;
        @(negedge clk);
        while (req_ready_o !== 1'b1 && wait_cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (req_ready_o !== 1'b1) begin
            note_timeout("bus request was never accepted");
        end
        // accepted on this edge
        @(posedge clk);
        req_valid_i <= 1'b0;
        we_i        <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (rsp_valid_o !== 1'b1 && wait_cnt < BUS_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rsp_valid_o !== 1'b1) begin
            note_timeout("no response on the bus");
        end else if (wait_cnt != 0) begin
            // response is due one cycle after acceptance
            errors++;
            $display("bus response arrived %0d cycles late", wait_cnt);
        end
        rdata = data_o;
    endtask

    task automatic reg_write(input reg_off_t off, input data_word_t data, input byte_sel_t sel);
        logic [31:0] upper;
        data_word_t  rsp;
        // upper address bits are not decoded
        upper = next_random();
        bus_access(1'b1, {upper[31:8], off}, data, sel, rsp);
        check_word("data_o on write", rsp, '0);
        shadow_write(off, data, sel);
    endtask

    task automatic reg_read(input reg_off_t off, output data_word_t data);
        logic [31:0] upper;
        upper = next_random();
        bus_access(1'b0, {upper[31:8], off}, '0, 4'h0, data);
    endtask

    // read status until a bit reaches the level
    task automatic poll_status(input int bit_pos, input logic level, input string what);
        data_word_t rd;
        int         polls;
        polls = 0;
        reg_read(`UART_OFF_STATUS, rd);
        while (rd[bit_pos] !== level && polls < POLL_LIMIT) begin
            reg_read(`UART_OFF_STATUS, rd);
            polls++;
        end
        if (rd[bit_pos] !== level) begin
            note_timeout(what);
        end
    endtask

    // drive one frame on rx_i, each bit div + 1 cycles
    task automatic send_frame(input baud_div_t div, input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (int'(div)) @(posedge clk);
        end
    endtask

    // decode one frame from tx_o, sampled mid-bit
    task automatic receive_frame(input baud_div_t div, output byte_t value,
                                 output logic stop_bit, output logic found);
        int wait_cnt;
        int bit_cycles;
        bit_cycles = int'(div) + 1;
        value      = '0;
        stop_bit   = 1'b0;
        wait_cnt   = 0;
        @(negedge clk);
        while (tx_o !== 1'b0 && wait_cnt < LINE_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        found = (tx_o === 1'b0);
        if (found) begin
            // middle of the start bit, then lsb first
            repeat (bit_cycles / 2) @(negedge clk);
            for (int i = 0; i < `UART_DATA_BITS; i++) begin
                repeat (bit_cycles) @(negedge clk);
                value[i] = tx_o;
            end
            repeat (bit_cycles) @(negedge clk);
            stop_bit = tx_o;
        end
    endtask

    initial begin
        data_word_t rd;
        logic [31:0] rnd;
        reg_off_t   off;
        byte_t      payload;
        byte_t      got_byte;
        logic       stop_bit;
        logic       found;
        logic       line_idle;
        int         frame_cycles;

        rst_n       <= 1'b0;
        addr_i      <= '0;
        data_i      <= '0;
        sel_i       <= '0;
        we_i        <= 1'b0;
        req_valid_i <= 1'b0;
        rsp_ready_i <= 1'b1;
        rx_i        <= 1'b1;
        rng_state   = 32'h7901_80e5;
        checks      = 0;
        errors      = 0;
        test_mark   = 0;
        exp_ctrl    = '0;
        exp_baud    = baud_div_t'(`UART_DEFAULT_BAUD);
        exp_busy    = 1'b0;
        exp_rx_over = 1'b0;
        exp_rx_data = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // reset values
        reg_read(`UART_OFF_CTRL, rd);
        check_word("ctrl", rd, expected_read(`UART_OFF_CTRL));
        reg_read(`UART_OFF_STATUS, rd);
        check_word("status", rd, expected_read(`UART_OFF_STATUS));
        reg_read(`UART_OFF_RXDATA, rd);
        check_word("rx data", rd, expected_read(`UART_OFF_RXDATA));
        reg_read(`UART_OFF_BAUD, rd);
        check_word("baud", rd, expected_read(`UART_OFF_BAUD));
        // unmapped offset
        reg_read(8'h20, rd);
        check_word("unmapped", rd, expected_read(8'h20));
        check_bit("tx_o", tx_o, 1'b1);
        report_test("reset values");

        // random lane writes, tx data left out
        for (int i = 0; i < 16; i++) begin
            rnd = next_random();
            case (rnd[1:0])
                2'd0:    off = `UART_OFF_CTRL;
                2'd1:    off = `UART_OFF_STATUS;
                2'd2:    off = `UART_OFF_BAUD;
                default: off = `UART_OFF_RXDATA;
            endcase
            reg_write(off, next_random(), rnd[7:4]);
            reg_read(off, rd);
            check_word("data_o", rd, expected_read(off));
        end
        report_test("byte lanes");

        // tx frame at baud 7
        reg_write(`UART_OFF_CTRL, 32'h1, 4'h1);
        reg_write(`UART_OFF_BAUD, 32'h7, 4'h3);
        rnd     = next_random();
        payload = rnd[7:0];
        reg_write(`UART_OFF_TXDATA, {24'h0, payload}, 4'h1);
        fork
            receive_frame(exp_baud, got_byte, stop_bit, found);
            begin
                // still inside the frame
                reg_read(`UART_OFF_STATUS, rd);
                check_word("status busy", rd, expected_read(`UART_OFF_STATUS));
            end
        join
        if (!found) begin
            note_timeout("no start bit on tx_o");
        end
        check_byte("tx_o byte", got_byte, payload);
        check_bit("tx_o stop bit", stop_bit, 1'b1);
        poll_status(`UART_STAT_TX_BUSY, 1'b0, "tx busy never cleared");
        exp_busy = 1'b0;
        reg_read(`UART_OFF_STATUS, rd);
        check_word("status idle", rd, expected_read(`UART_OFF_STATUS));
        report_test("tx frame");

        // tx disabled, line must stay idle for a frame time
        reg_write(`UART_OFF_CTRL, 32'h0, 4'h1);
        rnd = next_random();
        reg_write(`UART_OFF_TXDATA, rnd, 4'h1);
        frame_cycles = 10 * (int'(exp_baud) + 1);
        line_idle = 1'b1;
        repeat (frame_cycles) begin
            @(negedge clk);
            line_idle = line_idle & (tx_o === 1'b1);
        end
        check_bit("tx_o idle", line_idle, 1'b1);
        reg_read(`UART_OFF_STATUS, rd);
        check_word("status", rd, expected_read(`UART_OFF_STATUS));
        report_test("tx disabled");

        // rx byte, flag, read back, clear
        reg_write(`UART_OFF_CTRL, 32'h2, 4'h1);
        reg_write(`UART_OFF_STATUS, 32'h0, 4'h1);
        rnd     = next_random();
        payload = rnd[7:0];
        send_frame(exp_baud, payload);
        poll_status(`UART_STAT_RX_OVER, 1'b1, "received byte was never flagged");
        exp_rx_over = 1'b1;
        exp_rx_data = payload;
        reg_read(`UART_OFF_STATUS, rd);
        check_word("status", rd, expected_read(`UART_OFF_STATUS));
        reg_read(`UART_OFF_RXDATA, rd);
        check_word("rx data", rd, expected_read(`UART_OFF_RXDATA));
        check_byte("rx byte", rd[7:0], payload);
        reg_write(`UART_OFF_STATUS, 32'h0, 4'h1);
        reg_read(`UART_OFF_STATUS, rd);
        check_word("status cleared", rd, expected_read(`UART_OFF_STATUS));
        report_test("rx byte");

        // response held while rsp_ready_i is low
        @(posedge clk);
        rsp_ready_i <= 1'b0;
        reg_read(`UART_OFF_BAUD, rd);
        check_word("data_o", rd, expected_read(`UART_OFF_BAUD));
        repeat (5) begin
            @(negedge clk);
            check_bit("rsp_valid_o", rsp_valid_o, 1'b1);
            check_bit("req_ready_o", req_ready_o, 1'b0);
            check_word("data_o held", data_o, expected_read(`UART_OFF_BAUD));
        end
        @(posedge clk);
        rsp_ready_i <= 1'b1;
        @(negedge clk);
        check_bit("req_ready_o", req_ready_o, 1'b1);
        @(negedge clk);
        check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
        report_test("back-pressure");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== uart_macros.svh ====
// **************************************************
// uart clock, default baud divisor, register offsets
// and control/status bit positions
// **************************************************

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clock feeding the peripheral
`define UART_CLK_HZ        50000000

// 115200 baud at the system clock, one bit = divisor + 1 cycles
`define UART_DEFAULT_BAUD  (`UART_CLK_HZ / 115200)

// register offsets, low address byte
`define UART_OFF_CTRL      8'h00
`define UART_OFF_STATUS    8'h04
`define UART_OFF_BAUD      8'h08
`define UART_OFF_TXDATA    8'h0C
`define UART_OFF_RXDATA    8'h10

// control bits
`define UART_CTRL_TX_EN    0
`define UART_CTRL_RX_EN    1

// status bits, busy is read-only
`define UART_STAT_TX_BUSY  0
`define UART_STAT_RX_OVER  1

// payload width on the line
`define UART_DATA_BITS     8

`endif

// ==== uart_periph.f ====
+incdir+.
uart_pkg.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv

// ==== uart_pkg.sv ====
// **************************************************
// uart types: bus word, lane select, payload, divisor
// register offset, bit counter and tx state enum
// **************************************************

package uart_pkg;

    // bus address and data word
    typedef logic [31:0] data_word_t;

    // one select bit per byte lane
    typedef logic [3:0] byte_sel_t;

    // serial payload
    typedef logic [7:0] byte_t;

    // bit period in clocks is divisor + 1
    typedef logic [15:0] baud_div_t;

    // decoded low address byte
    typedef logic [7:0] reg_off_t;

    // data bit and sample counter
    typedef logic [3:0] bit_idx_t;

    // transmitter FSM states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

// ==== uart_regs.sv ====
// **************************************************
// uart register bank: valid/ready bus handshake,
// byte-lane writes, read response, tx start gating
// **************************************************

`include "uart_macros.svh"

module uart_regs import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  data_word_t addr_i,
    input  data_word_t data_i,
    input  byte_sel_t  sel_i,
    input  logic       we_i,
    input  logic       req_valid_i,
    input  logic       rsp_ready_i,
    input  logic       tx_done_i,
    input  logic       rx_valid_i,
    input  byte_t      rx_byte_i,
    output logic       req_ready_o,
    output logic       rsp_valid_o,
    output data_word_t data_o,
    output logic       tx_start_o,
    output byte_t      tx_byte_o,
    output baud_div_t  baud_div_o,
    output logic       rx_en_o
);

    reg_off_t   reg_off;
    logic       req_fire;
    logic       wr_fire;
    logic       wr_ctrl;
    logic       wr_status;
    logic       wr_baud;
    logic       tx_go;
    logic       rx_capture;
    data_word_t rd_data;

    logic       rsp_valid_q;
    data_word_t rsp_data_q;
    byte_t      ctrl_q;
    baud_div_t  baud_q;
    logic       tx_busy_q;
    logic       rx_over_q;
    byte_t      tx_byte_q;
    logic       tx_start_q;
    byte_t      rx_data_q;

    // only the low address byte is decoded
    assign reg_off = addr_i[7:0];

    // single response slot, free again when the pending one is taken
    assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;
    assign wr_fire     = req_fire & we_i;

    assign wr_ctrl   = wr_fire & (reg_off == `UART_OFF_CTRL);
    assign wr_status = wr_fire & (reg_off == `UART_OFF_STATUS);
    assign wr_baud   = wr_fire & (reg_off == `UART_OFF_BAUD);

    // new frame only when enabled and the line is free
    assign tx_go = wr_fire & (reg_off == `UART_OFF_TXDATA) & sel_i[0]
                 & ctrl_q[`UART_CTRL_TX_EN] & ~tx_busy_q;

    // received bytes are dropped while rx is disabled
    assign rx_capture = rx_valid_i & ctrl_q[`UART_CTRL_RX_EN];

    // read mux, tx data is write-only
    always_comb begin
        rd_data = '0;
        case (reg_off)
            `UART_OFF_CTRL: begin
                rd_data = data_word_t'(ctrl_q);
            end
            `UART_OFF_STATUS: begin
                rd_data[`UART_STAT_TX_BUSY] = tx_busy_q;
                rd_data[`UART_STAT_RX_OVER] = rx_over_q;
            end
            `UART_OFF_BAUD: begin
                rd_data = data_word_t'(baud_q);
            end
            `UART_OFF_RXDATA: begin
                rd_data = {{(32 - `UART_DATA_BITS){1'b0}}, rx_data_q};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // response register, holds under back-pressure
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_data_q  <= '0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
            // writes answer with zero
            rsp_data_q  <= we_i ? '0 : rd_data;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // control and baud byte lanes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            baud_q <= baud_div_t'(`UART_DEFAULT_BAUD);
        end else begin
            if (wr_ctrl && sel_i[0]) begin
                ctrl_q <= data_i[7:0];
            end
            if (wr_baud && sel_i[0]) begin
                baud_q[7:0] <= data_i[7:0];
            end
            if (wr_baud && sel_i[1]) begin
                baud_q[15:8] <= data_i[15:8];
            end
        end
    end

    // status flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy_q <= 1'b0;
            rx_over_q <= 1'b0;
        end else begin
            // busy from start until the stop bit ends
            if (tx_go) begin
                tx_busy_q <= 1'b1;
            end else if (tx_done_i) begin
                tx_busy_q <= 1'b0;
            end
            if (wr_status && sel_i[0]) begin
                rx_over_q <= data_i[`UART_STAT_RX_OVER];
            end
            // a new byte wins over a clearing write
            if (rx_capture) begin
                rx_over_q <= 1'b1;
            end
        end
    end

    // tx start pulse with its byte, rx byte capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_start_q <= 1'b0;
            tx_byte_q  <= '0;
            rx_data_q  <= '0;
        end else begin
            tx_start_q <= tx_go;
            if (tx_go) begin
                tx_byte_q <= data_i[7:0];
            end
            if (rx_capture) begin
                rx_data_q <= rx_byte_i;
            end
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign data_o      = rsp_data_q;
    assign tx_start_o  = tx_start_q;
    assign tx_byte_o   = tx_byte_q;
    assign baud_div_o  = baud_q;
    assign rx_en_o     = ctrl_q[`UART_CTRL_RX_EN];

endmodule

// ==== uart_rx.sv ====
// **************************************************
// uart receiver: line sync, start edge detect,
// mid-bit sampling and byte assembly
// **************************************************

module uart_rx import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  baud_div_t baud_div_i,
    input  logic      rx_en_i,
    input  logic      rx_i,
    output logic      rx_valid_o,
    output byte_t     rx_byte_o
);

    logic      sync_q1;
    logic      sync_q2;
    logic      line_prev_q;
    logic      line_fall;
    logic      active_q;
    baud_div_t period_cnt_q;
    baud_div_t period_lim;
    bit_idx_t  sample_idx_q;
    logic      sample;
    logic      valid_q;
    byte_t     shift_q;

    // two-flop synchroniser plus one delay for edge detect
    // reset to idle-high, no false start after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1     <= 1'b1;
            sync_q2     <= 1'b1;
            line_prev_q <= 1'b1;
        end else begin
            sync_q1     <= rx_i;
            sync_q2     <= sync_q1;
            line_prev_q <= sync_q2;
        end
    end

    // start edge on the synchronised line
    assign line_fall = line_prev_q & ~sync_q2;

    // half period to the middle of the start bit, then full periods
    assign period_lim = (sample_idx_q == 4'd0) ? (baud_div_i >> 1) : baud_div_i;
    assign sample     = active_q & (period_cnt_q == period_lim);

    // reception control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q     <= 1'b0;
            period_cnt_q <= '0;
            sample_idx_q <= '0;
            valid_q      <= 1'b0;
        end else if (!rx_en_i) begin
            // disabled, drop any frame in progress
            active_q     <= 1'b0;
            period_cnt_q <= '0;
            sample_idx_q <= '0;
            valid_q      <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!active_q) begin
                period_cnt_q <= '0;
                sample_idx_q <= '0;
                if (line_fall) begin
                    active_q <= 1'b1;
                end
            end else if (sample) begin
                period_cnt_q <= '0;
                sample_idx_q <= sample_idx_q + 4'd1;
                // sample 8 is the last data bit, stop bit not checked
                if (sample_idx_q == 4'd8) begin
                    active_q <= 1'b0;
                    valid_q  <= 1'b1;
                end
            end else begin
                period_cnt_q <= period_cnt_q + 16'd1;
            end
        end
    end

    // shift in msb side, first bit ends in bit 0
    // start bit sample (index 0) is skipped
    always_ff @(posedge clk) begin
        if (sample && (sample_idx_q != 4'd0)) begin
            shift_q <= {sync_q2, shift_q[7:1]};
        end
    end

    assign rx_valid_o = valid_q;
    assign rx_byte_o  = shift_q;

endmodule

// ==== uart_top.sv ====
// **************************************************
// uart peripheral top: register bank, transmitter
// and receiver
// **************************************************

module uart_top import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  data_word_t addr_i,
    input  data_word_t data_i,
    input  byte_sel_t  sel_i,
    input  logic       we_i,
    input  logic       req_valid_i,
    input  logic       rsp_ready_i,
    input  logic       rx_i,
    output data_word_t data_o,
    output logic       req_ready_o,
    output logic       rsp_valid_o,
    output logic       tx_o
);

    // regs to tx
    logic      tx_start;
    byte_t     tx_byte;
    logic      tx_done;
    // shared bit period
    baud_div_t baud_div;
    // rx to regs
    logic      rx_en;
    logic      rx_valid;
    byte_t     rx_byte;

    uart_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .sel_i       (sel_i),
        .we_i        (we_i),
        .req_valid_i (req_valid_i),
        .rsp_ready_i (rsp_ready_i),
        .tx_done_i   (tx_done),
        .rx_valid_i  (rx_valid),
        .rx_byte_i   (rx_byte),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .data_o      (data_o),
        .tx_start_o  (tx_start),
        .tx_byte_o   (tx_byte),
        .baud_div_o  (baud_div),
        .rx_en_o     (rx_en)
    );

    uart_tx tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_div_i (baud_div),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_done_o  (tx_done),
        .tx_o       (tx_o)
    );

    // instance name kept apart from the rx_i port
    uart_rx uart_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_div_i (baud_div),
        .rx_en_i    (rx_en),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

endmodule

// ==== uart_tx.sv ====
// **************************************************
// uart transmitter FSM: start, 8 data bits lsb first,
// stop, with registered line output and done pulse
// **************************************************

module uart_tx import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  baud_div_t baud_div_i,
    input  logic      tx_start_i,
    input  byte_t     tx_byte_i,
    output logic      tx_done_o,
    output logic      tx_o
);

    tx_state_t state_q;
    tx_state_t state_d;
    baud_div_t cycle_cnt_q;
    bit_idx_t  bit_idx_q;
    bit_idx_t  bit_idx_d;
    logic      bit_end;
    logic      tx_q;

    // last clock of the current bit
    assign bit_end = (cycle_cnt_q == baud_div_i);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_IDLE: begin
                if (tx_start_i) begin
                    state_d = TX_START;
                end
            end
            TX_START: begin
                if (bit_end) begin
                    state_d = TX_DATA;
                end
            end
            TX_DATA: begin
                // bit 7 is the last data bit
                if (bit_end && (bit_idx_q == 4'd7)) begin
                    state_d = TX_STOP;
                end
            end
            TX_STOP: begin
                if (bit_end) begin
                    state_d = TX_IDLE;
                end
            end
            default: begin
                state_d = TX_IDLE;
            end
        endcase
    end

    // data bit index, advances at each bit end
    always_comb begin
        if (state_q != TX_DATA) begin
            bit_idx_d = '0;
        end else if (bit_end) begin
            bit_idx_d = bit_idx_q + 4'd1;
        end else begin
            bit_idx_d = bit_idx_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= TX_IDLE;
            cycle_cnt_q <= '0;
            bit_idx_q   <= '0;
            // line idles high
            tx_q        <= 1'b1;
        end else begin
            state_q   <= state_d;
            bit_idx_q <= bit_idx_d;
            // period counter wraps at the divisor
            if ((state_q == TX_IDLE) || bit_end) begin
                cycle_cnt_q <= '0;
            end else begin
                cycle_cnt_q <= cycle_cnt_q + 16'd1;
            end
            // line level follows the next state, so no glitch
            case (state_d)
                TX_START: tx_q <= 1'b0;
                TX_DATA:  tx_q <= tx_byte_i[bit_idx_d[2:0]];
                default:  tx_q <= 1'b1;
            endcase
        end
    end

    // last cycle of the stop bit
    assign tx_done_o = (state_q == TX_STOP) & bit_end;
    assign tx_o      = tx_q;

endmodule
